// File: run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
# Exits with status 0 only when the pass message appears in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_cdc_bridge -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_cdc_bridge)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: src/bridge_macros.svh
// Build-time sizes for the multi-lane clock-domain bridge
// Included by the package and by every module that sizes a port or a counter
// Change the values here and rebuild to resize all lanes together

`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// Number of independent lanes
`define BRIDGE_LANES 4

// Slots in each lane FIFO
`define BRIDGE_DEPTH 4

// Sample payload width
`define BRIDGE_DATA_W 16

// Per-lane sequence number width, wraps silently
`define BRIDGE_SEQ_W 8

// Width of a lane number
`define BRIDGE_LANE_W ($clog2(`BRIDGE_LANES))

`endif

// File: src/bridge_pkg.sv
// Types exchanged between the bridge modules
// The producer sends in_word_t, the lane FIFOs carry lane_word_t
// and the merged read-side stream is out_word_t
// Widths come from the shared macro header

`include "bridge_macros.svh"

package bridge_pkg;

    // Producer sample as presented on the write side
    typedef struct packed {
        logic [`BRIDGE_LANE_W-1:0] lane;
        logic [`BRIDGE_DATA_W-1:0] data;
    } in_word_t;

    // Payload stored in one lane FIFO
    // The lane number is implied by which FIFO holds it
    typedef struct packed {
        logic [`BRIDGE_SEQ_W-1:0]  seq;
        logic [`BRIDGE_DATA_W-1:0] data;
    } lane_word_t;

    // Merged output word
    // Gaps in seq for a given lane mark dropped samples
    typedef struct packed {
        logic [`BRIDGE_LANE_W-1:0] lane;
        logic [`BRIDGE_SEQ_W-1:0]  seq;
        logic [`BRIDGE_DATA_W-1:0] data;
    } out_word_t;

endpackage

// File: src/cdc_bridge_top.sv
// Multi-lane clock-domain bridge
// Samples enter on wr_clk tagged with a lane number, pass through one
// toggle-flag FIFO per lane and leave on rd_clk as a single merged stream
// lane_full tells the producer which lanes will drop new samples
// out_en low stalls the merge and lets the lane FIFOs fill
`timescale 1ns/1ps
`include "bridge_macros.svh"

module cdc_bridge_top
    import bridge_pkg::*;
(
    input  logic                     wr_clk,
    input  logic                     rd_clk,
    input  logic                     rst_n,
    input  logic                     in_vld,
    input  in_word_t                 in_word,
    output logic [`BRIDGE_LANES-1:0] lane_full,
    input  logic                     out_en,
    output logic                     out_vld,
    output out_word_t                out_word
);

    logic [`BRIDGE_LANES-1:0] lane_wr_en;
    lane_word_t               lane_wdata;
    logic [`BRIDGE_LANES-1:0] lane_empty;
    logic [`BRIDGE_LANES-1:0] lane_rd_en;
    lane_word_t               lane_head [`BRIDGE_LANES];

    lane_dispatch u_dispatch (
        .wr_clk     (wr_clk),
        .rst_n      (rst_n),
        .in_vld     (in_vld),
        .in_word    (in_word),
        .lane_wr_en (lane_wr_en),
        .lane_wdata (lane_wdata)
    );

    // One FIFO per lane, all sharing the dispatcher's write data
    for (genvar i = 0; i < `BRIDGE_LANES; i++) begin : g_lane
        toggle_flag_fifo #(
            .DEPTH (`BRIDGE_DEPTH)
        ) u_fifo (
            .wr_clk (wr_clk),
            .rd_clk (rd_clk),
            .rst_n  (rst_n),
            .wr_en  (lane_wr_en[i]),
            .wdata  (lane_wdata),
            .full   (lane_full[i]),
            .rd_en  (lane_rd_en[i]),
            .rdata  (lane_head[i]),
            .empty  (lane_empty[i])
        );
    end

    lane_drain u_drain (
        .rd_clk     (rd_clk),
        .rst_n      (rst_n),
        .out_en     (out_en),
        .lane_empty (lane_empty),
        .lane_head  (lane_head),
        .lane_rd_en (lane_rd_en),
        .out_vld    (out_vld),
        .out_word   (out_word)
    );

endmodule

// File: src/lane_dispatch.sv
// Write-side dispatcher for the bridge
// Registers each producer sample, stamps it with its lane's sequence number
// and raises one lane write strobe on the following wr_clk cycle
// The sequence counter moves even when the lane FIFO drops the word
`timescale 1ns/1ps
`include "bridge_macros.svh"

module lane_dispatch
    import bridge_pkg::*;
(
    input  logic                     wr_clk,
    input  logic                     rst_n,
    input  logic                     in_vld,
    input  in_word_t                 in_word,
    output logic [`BRIDGE_LANES-1:0] lane_wr_en,
    output lane_word_t               lane_wdata
);

    logic [`BRIDGE_SEQ_W-1:0] seq_cnt [`BRIDGE_LANES];
    logic [`BRIDGE_LANES-1:0] lane_dec;

    // One-hot lane decode of the incoming sample
    always_comb begin
        lane_dec = '0;
        lane_dec[in_word.lane] = 1'b1;
    end

    // Strobe for exactly one cycle per sample
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_wr_en <= '0;
        end else if (in_vld) begin
            lane_wr_en <= lane_dec;
        end else begin
            lane_wr_en <= '0;
        end
    end

    // Per-lane sequence counters
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `BRIDGE_LANES; i++) begin
                seq_cnt[i] <= '0;
            end
        end else if (in_vld) begin
            seq_cnt[in_word.lane] <= seq_cnt[in_word.lane] + 1'b1;
        end
    end

    // Shared write data, only meaningful alongside a strobe
    always_ff @(posedge wr_clk) begin
        if (in_vld) begin
            lane_wdata.seq  <= seq_cnt[in_word.lane];
            lane_wdata.data <= in_word.data;
        end
    end

endmodule

// File: src/lane_drain.sv
// Read-side merge of the lane FIFOs
// Each cycle with out_en high it serves the first non-empty lane after
// the one served last, pops that lane and registers its head into out_word
// out_vld pulses for one rd_clk cycle per word
`timescale 1ns/1ps
`include "bridge_macros.svh"

module lane_drain
    import bridge_pkg::*;
(
    input  logic                     rd_clk,
    input  logic                     rst_n,
    input  logic                     out_en,
    input  logic [`BRIDGE_LANES-1:0] lane_empty,
    input  lane_word_t               lane_head [`BRIDGE_LANES],
    output logic [`BRIDGE_LANES-1:0] lane_rd_en,
    output logic                     out_vld,
    output out_word_t                out_word
);

    localparam int LANES  = `BRIDGE_LANES;
    localparam int LANE_W = `BRIDGE_LANE_W;

    logic [LANE_W-1:0] last_lane;
    logic [LANE_W-1:0] pick_lane;
    logic              pick_vld;
    logic              serve;

    // Round-robin search starting just after the last lane served
    always_comb begin
        int idx;
        pick_vld  = 1'b0;
        pick_lane = '0;
        for (int k = 1; k <= LANES; k++) begin
            idx = (int'(last_lane) + k) % LANES;
            if (!pick_vld && !lane_empty[idx]) begin
                pick_vld  = 1'b1;
                pick_lane = LANE_W'(idx);
            end
        end
    end

    assign serve = out_en && pick_vld;

    // Pop strobe goes out in the same cycle as the pick
    always_comb begin
        lane_rd_en = '0;
        if (serve) begin
            lane_rd_en[pick_lane] = 1'b1;
        end
    end

    // Start so that lane 0 is served first after reset
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            last_lane <= LANE_W'(LANES - 1);
        end else if (serve) begin
            last_lane <= pick_lane;
        end
    end

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
        end else begin
            out_vld <= serve;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (serve) begin
            out_word.lane <= pick_lane;
            out_word.seq  <= lane_head[pick_lane].seq;
            out_word.data <= lane_head[pick_lane].data;
        end
    end

endmodule

// File: src/toggle_flag_fifo.sv
// Two-clock FIFO built on per-slot toggle flags
// A slot holds data while its write flag and its read flag differ
// The write side flips its flag on a push, the read side on a pop
// A one-word tap register in front of the array gives fall-through reads
// so rdata is the head whenever empty is low
`timescale 1ns/1ps
`include "bridge_macros.svh"

module toggle_flag_fifo
    import bridge_pkg::*;
#(
    parameter int DEPTH = `BRIDGE_DEPTH
) (
    input  logic       wr_clk,
    input  logic       rd_clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  lane_word_t wdata,
    output logic       full,
    input  logic       rd_en,
    output lane_word_t rdata,
    output logic       empty
);

    localparam int PSIZE = $clog2(DEPTH);

    // Pointers and their one-ahead copies
    logic [PSIZE-1:0] wpoint;
    logic [PSIZE-1:0] wpoint_pre1;
    logic [PSIZE-1:0] rpoint;
    logic [PSIZE-1:0] rpoint_pre1;

    // One flag per slot in each domain
    logic [DEPTH-1:0] wr_flag;
    logic [DEPTH-1:0] rd_flag;

    lane_word_t data_array [DEPTH];

    logic array_empty;
    logic tap_vld;
    logic tap_req;
    logic wr_push;
    logic arr_pop;

    // Wraps at DEPTH so non power of two depths also work
    function automatic logic [PSIZE-1:0] next_ptr(input logic [PSIZE-1:0] p);
        if (p == PSIZE'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign wr_push = wr_en && !full;
    assign arr_pop = tap_req && !array_empty;

    // Write pointer, steps only on an accepted push
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wpoint      <= '0;
            wpoint_pre1 <= PSIZE'(1);
        end else if (wr_push) begin
            wpoint      <= wpoint_pre1;
            wpoint_pre1 <= next_ptr(wpoint_pre1);
        end
    end

    // Read pointer, steps when the tap pulls a word out of the array
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rpoint      <= '0;
            rpoint_pre1 <= PSIZE'(1);
        end else if (arr_pop) begin
            rpoint      <= rpoint_pre1;
            rpoint_pre1 <= next_ptr(rpoint_pre1);
        end
    end

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_flag <= '0;
        end else if (wr_push) begin
            wr_flag[wpoint] <= ~wr_flag[wpoint];
        end
    end

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_flag <= '0;
        end else if (arr_pop) begin
            rd_flag[rpoint] <= ~rd_flag[rpoint];
        end
    end

    // Full looks one slot ahead when a push is in flight
    // Held high in reset and released on the first wr_clk edge
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b1;
        end else if (wr_push) begin
            full <= wr_flag[wpoint_pre1] != rd_flag[wpoint_pre1];
        end else begin
            full <= wr_flag[wpoint] != rd_flag[wpoint];
        end
    end

    // Array empty mirrors full on the read side
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            array_empty <= 1'b1;
        end else if (arr_pop) begin
            array_empty <= wr_flag[rpoint_pre1] == rd_flag[rpoint_pre1];
        end else begin
            array_empty <= wr_flag[rpoint] == rd_flag[rpoint];
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_push) begin
            data_array[wpoint] <= wdata;
        end
    end

    // Output tap
    // Refills whenever it is empty or its word is being consumed
    assign tap_req = !tap_vld || rd_en;

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            tap_vld <= 1'b0;
        end else if (tap_req) begin
            tap_vld <= !array_empty;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (arr_pop) begin
            rdata <= data_array[rpoint];
        end
    end

    assign empty = !tap_vld;

endmodule

// File: verif/tb_cdc_bridge.sv
// Self-checking testbench for the multi-lane clock-domain bridge
// Sends random lane samples on wr_clk, keeps one queue model per lane and
// checks every merged output word on rd_clk against the head of its queue
// Runs reset, ordering, overflow, round-robin fairness and final drain checks
`timescale 1ns/1ps
`include "bridge_macros.svh"

module tb_cdc_bridge
    import bridge_pkg::*;
();

    localparam int LANES        = `BRIDGE_LANES;
    localparam int DEPTH        = `BRIDGE_DEPTH;
    localparam int LANE_W       = `BRIDGE_LANE_W;
    localparam int N_RANDOM     = 200;
    localparam int N_BURST      = 10;
    localparam int FILL_ROUNDS  = 2 * DEPTH + 2;
    localparam int TOTAL_WRITES = N_RANDOM + N_BURST + 1 + FILL_ROUNDS * LANES;
    localparam int CYCLE_LIMIT  = TOTAL_WRITES * 40 + 2000;
    localparam int DRAIN_LIMIT  = LANES * (DEPTH + 1) * 40;

    logic             rd_clk = 1'b0;
    logic             wr_clk = 1'b0;
    logic             rst_n;
    logic             in_vld;
    in_word_t         in_word;
    logic [LANES-1:0] lane_full;
    logic             out_en;
    logic             out_vld;
    out_word_t        out_word;

    // Lane model filled one wr_clk cycle after each strobe
    lane_word_t               model_q [LANES][$];
    logic [`BRIDGE_SEQ_W-1:0] model_seq [LANES];
    int                       accept_cnt [LANES];
    int                       out_cnt [LANES];
    logic                     pend_vld;
    int                       pend_lane;
    lane_word_t               pend_word;

    logic [31:0] rng_state = 32'h2989_1e6e;
    int          cycle_cnt;
    int          mismatch_cnt;
    int          other_err_cnt;
    string       test_name;

    // Round-robin tracking while the fairness test drains
    logic fair_on;
    int   fair_seen;
    int   fair_prev;

    always #4 rd_clk = ~rd_clk;

    // Half period of 5.5 ns keeps wr_clk edges off the rd_clk edges
    always #5.5 wr_clk = ~wr_clk;

    cdc_bridge_top UUT (
        .wr_clk    (wr_clk),
        .rd_clk    (rd_clk),
        .rst_n     (rst_n),
        .in_vld    (in_vld),
        .in_word   (in_word),
        .lane_full (lane_full),
        .out_en    (out_en),
        .out_vld   (out_vld),
        .out_word  (out_word)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int queued_words();
        int total;
        total = 0;
        for (int l = 0; l < LANES; l++) begin
            total += model_q[l].size();
        end
        return total;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected 0x%0h, actual 0x%0h at %0t",
                     name, expected, actual, $time);
            mismatch_cnt++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR: %s at %0t", msg, $time);
        other_err_cnt++;
    endtask

    task automatic drive_word(input int lane, input logic [`BRIDGE_DATA_W-1:0] data);
        @(posedge wr_clk);
        in_vld       <= 1'b1;
        in_word.lane <= LANE_W'(lane);
        in_word.data <= data;
    endtask

    task automatic drive_idle();
        @(posedge wr_clk);
        in_vld <= 1'b0;
    endtask

    task automatic set_out_en(input logic value);
        @(posedge rd_clk);
        out_en <= value;
    endtask

    // Let the write pipeline settle and wait for the model to empty
    task automatic wait_drained();
        int waited;
        waited = 0;
        repeat (3) @(posedge wr_clk);
        while (queued_words() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge rd_clk);
            waited++;
        end
        if (queued_words() != 0) begin
            report_failure($sformatf("%s: %0d accepted words never came out",
                                     test_name, queued_words()));
        end
        repeat (4) @(posedge rd_clk);
    endtask

    // Write side model keeps a sample if its lane was not full at the write edge
    always @(posedge wr_clk) begin
        if (pend_vld && !lane_full[pend_lane]) begin
            model_q[pend_lane].push_back(pend_word);
            accept_cnt[pend_lane]++;
        end
        pend_vld = in_vld;
        if (in_vld) begin
            pend_lane      = int'(in_word.lane);
            pend_word.seq  = model_seq[pend_lane];
            pend_word.data = in_word.data;
            model_seq[pend_lane] = model_seq[pend_lane] + 1'b1;
        end
    end

    // Read side monitor and run limit
    always @(posedge rd_clk) begin
        int         lane;
        lane_word_t exp_word;
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("ERROR: run did not finish within %0d rd_clk cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end else if (!rst_n) begin
            compare_value("reset out_vld", 32'd0, 32'(out_vld));
            compare_value("reset lane_full", 32'((1 << LANES) - 1), 32'(lane_full));
        end else if (out_vld) begin
            lane = int'(out_word.lane);
            out_cnt[lane]++;
            if (model_q[lane].size() == 0) begin
                report_failure($sformatf("%s: output word on lane %0d with none expected",
                                         test_name, lane));
            end else begin
                exp_word = model_q[lane].pop_front();
                compare_value({test_name, " seq"}, 32'(exp_word.seq), 32'(out_word.seq));
                compare_value({test_name, " data"}, 32'(exp_word.data), 32'(out_word.data));
            end
            if (fair_on) begin
                if (fair_seen > 0 && fair_seen < LANES * DEPTH) begin
                    compare_value("fairness lane", 32'((fair_prev + 1) % LANES), 32'(lane));
                end
                fair_prev = lane;
                fair_seen++;
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] g;
        int          lane;
        int          sent;
        int          base_acc;
        int          base_out;
        int          accepted;
        int          rounds;
        int          total_acc;
        int          total_out;
        rst_n         = 1'b1;
        in_vld        = 1'b0;
        in_word       = '0;
        out_en        = 1'b0;
        pend_vld      = 1'b0;
        fair_on       = 1'b0;
        fair_seen     = 0;
        fair_prev     = 0;
        cycle_cnt     = 0;
        mismatch_cnt  = 0;
        other_err_cnt = 0;
        test_name     = "reset";
        for (int l = 0; l < LANES; l++) begin
            model_seq[l]  = '0;
            accept_cnt[l] = 0;
            out_cnt[l]    = 0;
        end

        // Reset followed by an idle drain that must produce nothing
        @(posedge rd_clk);
        rst_n <= 1'b0;
        repeat (8) @(posedge rd_clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge wr_clk);
        compare_value("reset lane_full release", 32'd0, 32'(lane_full));
        set_out_en(1'b1);
        repeat (20) @(posedge rd_clk);

        // Random lanes and data with the merge running
        test_name = "integrity";
        sent = 0;
        while (sent < N_RANDOM) begin
            g = next_random();
            r = next_random();
            if (g[31:30] != 2'b00) begin
                drive_word(int'(r[31:24]) % LANES, r[23:8]);
                sent++;
            end else begin
                drive_idle();
            end
        end
        drive_idle();
        wait_drained();

        // Burst into one stalled lane
        test_name = "overflow";
        set_out_en(1'b0);
        r = next_random();
        lane = int'(r[31:24]) % LANES;
        base_acc = accept_cnt[lane];
        base_out = out_cnt[lane];
        repeat (N_BURST) begin
            r = next_random();
            drive_word(lane, r[31:16]);
        end
        drive_idle();
        repeat (2) @(posedge wr_clk);
        accepted = accept_cnt[lane] - base_acc;
        compare_value("overflow lane_full", 32'd1, 32'(lane_full[lane]));
        if (accepted < DEPTH || accepted > DEPTH + 1) begin
            report_failure($sformatf("overflow: lane %0d kept %0d words, outside its capacity",
                                     lane, accepted));
        end
        set_out_en(1'b1);
        wait_drained();
        compare_value("overflow output count", 32'(accepted), 32'(out_cnt[lane] - base_out));

        // The next word on that lane carries the seq gap left by the drops
        r = next_random();
        drive_word(lane, r[31:16]);
        drive_idle();
        wait_drained();

        // Fill every lane with the merge stopped and check the rotation
        test_name = "fairness";
        set_out_en(1'b0);
        rounds = 0;
        while (lane_full != '1 && rounds < FILL_ROUNDS) begin
            for (int l = 0; l < LANES; l++) begin
                r = next_random();
                drive_word(l, r[31:16]);
            end
            rounds++;
        end
        drive_idle();
        repeat (2) @(posedge wr_clk);
        if (lane_full != '1) begin
            report_failure("fairness: not every lane reported full while the merge was stopped");
        end
        for (int l = 0; l < LANES; l++) begin
            if (model_q[l].size() < DEPTH) begin
                report_failure($sformatf("fairness: lane %0d holds only %0d words",
                                         l, model_q[l].size()));
            end
        end
        fair_seen = 0;
        fair_on   = 1'b1;
        set_out_en(1'b1);
        wait_drained();
        fair_on = 1'b0;
        if (fair_seen < LANES * DEPTH) begin
            report_failure($sformatf("fairness: only %0d words came out", fair_seen));
        end

        // Final drain and watch for stray outputs
        test_name = "completion";
        wait_drained();
        repeat (50) @(posedge rd_clk);
        total_acc = 0;
        total_out = 0;
        for (int l = 0; l < LANES; l++) begin
            total_acc += accept_cnt[l];
            total_out += out_cnt[l];
        end
        compare_value("completion word count", 32'(total_acc), 32'(total_out));

        $display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+src
src/bridge_pkg.sv
src/toggle_flag_fifo.sv
src/lane_dispatch.sv
src/lane_drain.sv
src/cdc_bridge_top.sv
verif/tb_cdc_bridge.sv
